// ==== common/img_geom_pkg.sv ====
// image geometry for the edge unit
// fixed 80 x 60 frame, address and raster count types
`default_nettype none

package img_geom_pkg;

  // frame size
  localparam int img_cols = 80;                 // pixels per line
  localparam int img_rows = 60;                 // lines per frame
  localparam int img_pxls = img_cols * img_rows; // 4800 pixels

  // counter widths
  localparam int nb_img_pxls  = 13; // 4800 < 2**13
  localparam int nb_line_pxls = 7;  // column count, 80 < 2**7
  localparam int nb_rows      = 6;  // row count, 60 < 2**6

  // three kernel pixels of each line live in registers, not in the buffer
  localparam int lbuf_depth = img_cols - 3;

  // entering pixel to kernel centre: one line plus two pixels
  localparam int kern_lag = img_cols + 2;

  typedef logic [nb_img_pxls-1:0]  img_addr_t; // linear frame address
  typedef logic [nb_line_pxls-1:0] col_t;      // column number
  typedef logic [nb_rows-1:0]      row_t;      // row number

endpackage

`default_nettype wire

// ==== common/pxl_pkg.sv ====
// pixel formats of the edge unit
// memory word layouts, gray weights and filter select codes
`default_nettype none

package pxl_pkg;

  localparam int nb_gray = 8;           // gray level
  localparam int nb_chan = 4;           // one color channel
  localparam int nb_buf  = 3 * nb_chan; // original memory word, 12 bits

  typedef logic [nb_gray-1:0] gray_t;

  // a source word is either padded gray or rgb 4:4:4
  typedef union packed {
    struct packed {
      logic [nb_chan-1:0] pad; // unused in gray mode
      gray_t              lvl;
    } gray;
    struct packed {
      logic [nb_chan-1:0] red;
      logic [nb_chan-1:0] green;
      logic [nb_chan-1:0] blue;
    } rgb;
  } src_pxl_u;

  // rgb to gray weights, 15 * (5 + 9 + 3) = 255 so no overflow
  localparam gray_t wt_red   = 8'd5;
  localparam gray_t wt_green = 8'd9;
  localparam gray_t wt_blue  = 8'd3;

  // filter select, bit 0 clear is filter off
  typedef logic [1:0] filt_t;

  localparam filt_t filt_hor = 2'b01; // horizontal sobel
  localparam filt_t filt_ver = 2'b11; // vertical sobel

endpackage

`default_nettype wire

// ==== src/frame_buf.sv ====
// frame memory, one full image deep
// one write port and one registered read port on the same clock
// used for both the original and the processed image
`timescale 1ns/1ps
`default_nettype none

module frame_buf #(
  parameter int nb_word = pxl_pkg::nb_buf // word width
) (
  input  wire                            rst,   // clock
  input  wire                            we,    // write strobe
  input  wire img_geom_pkg::img_addr_t   waddr,
  input  wire logic [nb_word-1:0]        wdata,
  input  wire img_geom_pkg::img_addr_t   raddr,
  output logic [nb_word-1:0]             rdata  // valid one cycle after raddr
);

  import img_geom_pkg::*;

  logic [nb_word-1:0] mem [img_pxls]; // block ram, no reset

  // write at the edge
  always_ff @(posedge rst) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, old data on a same-address collision
  always_ff @(posedge rst) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// ==== edge_proc/pxl_to_gray.sv ====
// source word to gray level
// gray mode takes the low byte, rgb mode the weighted channel sum
`timescale 1ns/1ps
`default_nettype none

module pxl_to_gray (
  input  wire pxl_pkg::src_pxl_u word,     // word from the original memory
  input  wire                    rgb_mode, // 1: word holds rgb 4:4:4
  output pxl_pkg::gray_t         gray
);

  import pxl_pkg::*;

  gray_t red_part;   // weighted channels
  gray_t green_part;
  gray_t blue_part;

  // channels widen to 8 bits, max product 15 * 9
  assign red_part   = gray_t'(word.rgb.red)   * wt_red;
  assign green_part = gray_t'(word.rgb.green) * wt_green;
  assign blue_part  = gray_t'(word.rgb.blue)  * wt_blue;

  always_comb begin
    if (rgb_mode) begin
      gray = red_part + green_part + blue_part; // tops out at 255
    end else begin
      gray = word.gray.lvl; // pad bits ignored
    end
  end

endmodule

`default_nettype wire

// ==== edge_proc/edge_proc.sv ====
// sobel edge processor
// streams the original image in raster order, builds a 3x3 kernel from
// two line buffers and writes one result per cycle to the processed image
`timescale 1ns/1ps
`default_nettype none

module edge_proc (
  input  wire                       rst,        // clock
  input  wire                       clk,        // async reset, active high
  input  wire                       run,        // level, scan enable
  input  wire pxl_pkg::filt_t       edgefilter, // x0 off, 01 hor, 11 ver
  input  wire                       rgb_mode,   // source words are rgb
  input  wire pxl_pkg::src_pxl_u    orig_pxl,   // one cycle after orig_addr
  output img_geom_pkg::img_addr_t   orig_addr,
  output logic                      proc_we,
  output pxl_pkg::gray_t            proc_pxl,
  output img_geom_pkg::img_addr_t   proc_addr,
  output logic                      frame_done  // one-cycle pulse
);

  import img_geom_pkg::*;
  import pxl_pkg::*;

  img_addr_t cnt_pxl;    // read address counter
  img_addr_t pxl_in_num; // pixel now on orig_pxl
  logic      end_pxl_cnt;
  logic      pxl_vld;    // orig_pxl holds a fresh pixel

  gray_t gray_in;

  // raster position of the entering pixel
  col_t col_in;
  row_t row_in;
  logic end_line;

  col_t buf_pt; // shared pointer of both line buffers
  logic end_buf_cnt;

  gray_t lbuf_1 [lbuf_depth]; // feeds the middle kernel row
  gray_t lbuf_2 [lbuf_depth]; // feeds the top kernel row

  // kernel, row 2 is the newest line, column 2 the newest pixel
  //  p00 p01 p02
  //  p10 p11 p12
  //  p20 p21 p22
  gray_t p00, p01, p02;
  gray_t p10, p11, p12;
  gray_t p20, p21, p22;

  logic ctr_wrap; // centre lies two lines back
  logic first_col, last_col, first_row, last_row;
  logic border;

  gray_t sob_hor;
  gray_t sob_ver;

  // |(b0 + 2*b1 + b2) - (a0 + 2*a1 + a2)|, saturated to 8 bits
  function automatic gray_t sobel_mag(input gray_t a0, a1, a2, b0, b1, b2);
    logic [nb_gray+1:0] sum_a; // up to 4 * 255
    logic [nb_gray+1:0] sum_b;
    logic [nb_gray+1:0] diff;
    sum_a = {2'b00, a0} + {1'b0, a1, 1'b0} + {2'b00, a2};
    sum_b = {2'b00, b0} + {1'b0, b1, 1'b0} + {2'b00, b2};
    diff  = (sum_b > sum_a) ? sum_b - sum_a : sum_a - sum_b;
    if (diff[nb_gray+1:nb_gray] != 2'b00) begin
      return '1; // clip at 255
    end
    return diff[nb_gray-1:0];
  endfunction

  pxl_to_gray i_pxl_to_gray (
    .word     (orig_pxl),
    .rgb_mode (rgb_mode),
    .gray     (gray_in)
  );

  assign end_pxl_cnt = (cnt_pxl == img_addr_t'(img_pxls - 1));
  assign orig_addr   = cnt_pxl;

  // read side, steps with run
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      cnt_pxl    <= '0;
      pxl_in_num <= '0;
      pxl_vld    <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      pxl_vld    <= run;                 // memory data lags one cycle
      frame_done <= run && end_pxl_cnt;  // after the last address
      if (run) begin
        pxl_in_num <= cnt_pxl;
        if (end_pxl_cnt) begin
          cnt_pxl <= '0;
        end else begin
          cnt_pxl <= cnt_pxl + img_addr_t'(1);
        end
      end
    end
  end

  assign end_buf_cnt = (buf_pt == col_t'(lbuf_depth - 1));
  assign end_line    = (col_in == col_t'(img_cols - 1));

  // data side, steps once per pixel received
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      buf_pt <= '0;
      col_in <= '0;
      row_in <= '0;
    end else if (pxl_vld) begin
      if (end_buf_cnt) begin
        buf_pt <= '0;
      end else begin
        buf_pt <= buf_pt + col_t'(1);
      end
      if (end_line) begin
        col_in <= '0;
        if (row_in == row_t'(img_rows - 1)) begin
          row_in <= '0;
        end else begin
          row_in <= row_in + row_t'(1);
        end
      end else begin
        col_in <= col_in + col_t'(1);
      end
    end
  end

  // circular line buffers, read and written at the same pointer
  always_ff @(posedge rst) begin
    if (pxl_vld) begin
      lbuf_1[buf_pt] <= p20;
      lbuf_2[buf_pt] <= p10;
    end
  end

  always_ff @(posedge rst) begin
    if (pxl_vld) begin
      p22 <= gray_in;          // bottom row straight from memory
      p21 <= p22;
      p20 <= p21;
      p12 <= lbuf_1[buf_pt];   // one line older
      p11 <= p12;
      p10 <= p11;
      p02 <= lbuf_2[buf_pt];   // two lines older
      p01 <= p02;
      p00 <= p01;
    end
  end

  // centre is entering pixel minus one line and two pixels
  assign ctr_wrap  = (col_in < col_t'(2));
  assign first_col = (col_in == col_t'(2));
  assign last_col  = (col_in == col_t'(1));
  assign first_row = ctr_wrap ? (row_in == row_t'(2)) : (row_in == row_t'(1));
  assign last_row  = ctr_wrap ? (row_in == row_t'(1)) : (row_in == '0);
  assign border    = first_col || last_col || first_row || last_row;

  assign sob_hor = sobel_mag(p00, p01, p02, p20, p21, p22); // bottom vs top
  assign sob_ver = sobel_mag(p00, p10, p20, p02, p12, p22); // right vs left

  always_comb begin
    case (edgefilter)
      filt_hor: proc_pxl = border ? '0 : sob_hor;
      filt_ver: proc_pxl = border ? '0 : sob_ver;
      default:  proc_pxl = p11; // filter off, centre as is
    endcase
  end

  // address of the kernel centre, modulo the frame
  assign proc_addr = (pxl_in_num >= img_addr_t'(kern_lag)) ?
                     pxl_in_num - img_addr_t'(kern_lag) :
                     pxl_in_num + img_addr_t'(img_pxls - kern_lag);
  assign proc_we   = pxl_vld;

endmodule

`default_nettype wire

// ==== src/edge_top.sv ====
// edge unit top level
// original image memory -> edge_proc -> processed image memory
// host loads source words and reads results through plain ports
`timescale 1ns/1ps
`default_nettype none

module edge_top (
  input  wire                            rst,        // clock
  input  wire                            clk,        // async reset, active high
  input  wire                            run,        // level, scan frames
  input  wire pxl_pkg::filt_t            edgefilter, // stable while run
  input  wire                            rgb_mode,   // stable while run
  input  wire                            load_we,    // host write strobe
  input  wire img_geom_pkg::img_addr_t   load_addr,
  input  wire pxl_pkg::src_pxl_u         load_pxl,
  input  wire img_geom_pkg::img_addr_t   rd_addr,
  output pxl_pkg::gray_t                 rd_pxl,     // one cycle after rd_addr
  output logic                           frame_done
);

  import img_geom_pkg::*;
  import pxl_pkg::*;

  wire img_addr_t orig_addr; // scan read address
  wire src_pxl_u  orig_pxl;
  wire            proc_we;
  wire img_addr_t proc_addr;
  wire gray_t     proc_pxl;

  // source image, host side write
  frame_buf #(
    .nb_word (nb_buf)
  ) i_orig_mem (
    .rst   (rst),
    .we    (load_we),
    .waddr (load_addr),
    .wdata (load_pxl),
    .raddr (orig_addr),
    .rdata (orig_pxl)
  );

  edge_proc i_edge_proc (
    .rst        (rst),
    .clk        (clk),
    .run        (run),
    .edgefilter (edgefilter),
    .rgb_mode   (rgb_mode),
    .orig_pxl   (orig_pxl),
    .orig_addr  (orig_addr),
    .proc_we    (proc_we),
    .proc_pxl   (proc_pxl),
    .proc_addr  (proc_addr),
    .frame_done (frame_done)
  );

  // result image, host side read
  frame_buf #(
    .nb_word (nb_gray)
  ) i_proc_mem (
    .rst   (rst),
    .we    (proc_we),
    .waddr (proc_addr),
    .wdata (proc_pxl),
    .raddr (rd_addr),
    .rdata (rd_pxl)
  );

endmodule

`default_nettype wire

// ==== verification/edge_top_sva.sv ====
// concurrent checks on the edge processor
// write strobe, address range and frame_done pulse shape
`timescale 1ns/1ps
`default_nettype none

module edge_top_sva (
  input wire                          rst,       // clock
  input wire                          clk,       // async reset
  input wire                          run,
  input wire                          proc_we,
  input wire img_geom_pkg::img_addr_t proc_addr,
  input wire                          frame_done
);

  import img_geom_pkg::*;

  // a write needs a pixel fetched the cycle before
  a_we_needs_run : assert property (@(posedge rst) disable iff (clk)
    !$past(run) |-> !proc_we)
    else $error("proc_we high although run was low one cycle earlier");

  a_addr_range : assert property (@(posedge rst) disable iff (clk)
    proc_we |-> (proc_addr < img_addr_t'(img_pxls)))
    else $error("proc_addr beyond the frame");

  a_done_pulse : assert property (@(posedge rst) disable iff (clk)
    frame_done |=> !frame_done)
    else $error("frame_done held for two cycles");

  // quiet outputs while reset is held
  a_reset_quiet : assert property (@(posedge rst)
    clk |-> (!proc_we && !frame_done))
    else $error("proc_we or frame_done active during reset");

endmodule

bind edge_proc edge_top_sva i_edge_top_sva (
  .rst        (rst),
  .clk        (clk),
  .run        (run),
  .proc_we    (proc_we),
  .proc_addr  (proc_addr),
  .frame_done (frame_done)
);

`default_nettype wire

// ==== verification/tb_edge_top.sv ====
// testbench for the edge unit
// random, stripe and rgb images through pass-through and both sobel modes,
// each processed pixel checked against a behavioral model
`timescale 1ns/1ps
`default_nettype none

module tb_edge_top;

  import img_geom_pkg::*;
  import pxl_pkg::*;

  localparam int frame_tmo  = 2 * img_pxls; // cycles per frame, room for stalls
  localparam int img_rand   = 0;
  localparam int img_stripe = 1;

  logic      rst = 1'b0; // clock
  logic      clk;        // async reset
  logic      run;
  filt_t     edgefilter;
  logic      rgb_mode;
  logic      load_we;
  img_addr_t load_addr;
  src_pxl_u  load_pxl;
  img_addr_t rd_addr;
  gray_t     rd_pxl;
  logic      frame_done;

  src_pxl_u    src_img [img_pxls]; // model copy of the original memory
  int unsigned seed_dummy;

  edge_top i_dut (
    .rst        (rst),
    .clk        (clk),
    .run        (run),
    .edgefilter (edgefilter),
    .rgb_mode   (rgb_mode),
    .load_we    (load_we),
    .load_addr  (load_addr),
    .load_pxl   (load_pxl),
    .rd_addr    (rd_addr),
    .rd_pxl     (rd_pxl),
    .frame_done (frame_done)
  );

  always #2 rst = ~rst; // 4 ns period

  // inputs change here, registered outputs have settled
  task automatic drive_slot();
    @(posedge rst);
    #0.5;
  endtask

  task automatic check_gray(input string name, input gray_t exp, input gray_t act);
    if (act !== exp) begin
      $display("** Error: %s expected %h, got %h", name, exp, act);
      $display("Test failed");
      $fatal(1, "gray value mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s expected %h, got %h", name, exp, act);
      $display("Test failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  // gray level of one source pixel, weights 5 9 3 in rgb mode
  function automatic int gray_at(input int r, input int c);
    src_pxl_u w;
    w = src_img[r * img_cols + c];
    if (rgb_mode) begin
      return int'(w.rgb.red) * int'(wt_red) + int'(w.rgb.green) * int'(wt_green)
             + int'(w.rgb.blue) * int'(wt_blue);
    end
    return int'(w.gray.lvl); // pad ignored
  endfunction

  // model of one processed pixel
  function automatic gray_t expected_pxl(input int a, input filt_t f);
    int r, c, sa, sb, d;
    r = a / img_cols;
    c = a % img_cols;
    if (!f[0]) begin
      return gray_t'(gray_at(r, c)); // filter off
    end
    if (r == 0 || r == img_rows - 1 || c == 0 || c == img_cols - 1) begin
      return '0;
    end
    if (f[1]) begin // vertical, left vs right column
      sa = gray_at(r - 1, c - 1) + 2 * gray_at(r, c - 1) + gray_at(r + 1, c - 1);
      sb = gray_at(r - 1, c + 1) + 2 * gray_at(r, c + 1) + gray_at(r + 1, c + 1);
    end else begin // horizontal, top vs bottom row
      sa = gray_at(r - 1, c - 1) + 2 * gray_at(r - 1, c) + gray_at(r - 1, c + 1);
      sb = gray_at(r + 1, c - 1) + 2 * gray_at(r + 1, c) + gray_at(r + 1, c + 1);
    end
    d = (sb > sa) ? sb - sa : sa - sb;
    return (d > 255) ? 8'hff : gray_t'(d); // saturate
  endfunction

  // host write of a whole image, run stays low
  task automatic load_image(input int kind);
    logic [nb_buf-1:0] word;
    int r, c;
    for (int a = 0; a < img_pxls; a++) begin
      r = a / img_cols;
      c = a % img_cols;
      if (kind == img_stripe) begin
        word = (((r / 2) + (c / 2)) % 2 == 1) ? 12'h0ff : 12'h000; // 2x2 blocks
      end else begin
        word = nb_buf'($urandom);
      end
      src_img[a] = word;
      drive_slot();
      load_we   = 1'b1;
      load_addr = img_addr_t'(a);
      load_pxl  = word;
    end
    drive_slot();
    load_we = 1'b0;
  endtask

  // waits for one frame_done pulse, optionally dropping run at random
  task automatic wait_frame_done(input bit stalls);
    int cyc;
    cyc = 0;
    drive_slot();
    while (!frame_done) begin
      if (cyc >= frame_tmo) begin
        $display("timeout: no frame_done pulse within %0d cycles", frame_tmo);
        $display("Test failed");
        $fatal(1, "frame_done timeout");
      end
      if (stalls) begin
        if (run) begin
          run = ($urandom_range(0, 299) != 0); // rare drop
        end else begin
          run = ($urandom_range(0, 3) == 0);   // few cycles low
        end
      end
      cyc++;
      drive_slot();
    end
    drive_slot();
    check_flag("frame_done", 1'b0, frame_done); // single-cycle pulse
  endtask

  task automatic run_frames(input bit stalls);
    drive_slot();
    run = 1'b1;
    repeat (2) wait_frame_done(stalls);
    drive_slot();
    run = 1'b0;
  endtask

  // reads the processed image, one address per cycle, pipelined
  task automatic read_check(input filt_t f);
    drive_slot();
    rd_addr = '0;
    for (int a = 1; a <= img_pxls; a++) begin
      drive_slot();
      check_gray($sformatf("rd_pxl[%0d]", a - 1), expected_pxl(a - 1, f), rd_pxl);
      if (a < img_pxls) begin
        rd_addr = img_addr_t'(a);
      end
    end
  endtask

  initial begin
    seed_dummy = $urandom(59);
    clk        = 1'b1;
    run        = 1'b0;
    edgefilter = 2'b00;
    rgb_mode   = 1'b0;
    load_we    = 1'b0;
    load_addr  = '0;
    load_pxl   = '0;
    rd_addr    = '0;
    repeat (4) drive_slot();
    clk = 1'b0;
    drive_slot();
    check_flag("frame_done", 1'b0, frame_done);

    load_image(img_rand); // pass-through, gray
    run_frames(1'b0);
    read_check(2'b00);

    edgefilter = filt_hor; // horizontal on the same image, then stripes
    run_frames(1'b0);
    read_check(filt_hor);
    load_image(img_stripe);
    run_frames(1'b0);
    read_check(filt_hor);

    edgefilter = filt_ver; // vertical, stripes then random
    run_frames(1'b0);
    read_check(filt_ver);
    load_image(img_rand);
    run_frames(1'b0);
    read_check(filt_ver);

    rgb_mode   = 1'b1; // rgb channels, off then vertical
    edgefilter = 2'b00;
    load_image(img_rand);
    run_frames(1'b0);
    read_check(2'b00);
    edgefilter = filt_ver;
    run_frames(1'b0);
    read_check(filt_ver);

    rgb_mode   = 1'b0; // run dropped mid-frame
    edgefilter = filt_hor;
    load_image(img_rand);
    run_frames(1'b1);
    read_check(filt_hor);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
common/img_geom_pkg.sv
common/pxl_pkg.sv
src/frame_buf.sv
edge_proc/pxl_to_gray.sv
edge_proc/edge_proc.sv
src/edge_top.sv
verification/edge_top_sva.sv
verification/tb_edge_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the edge unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module tb_edge_top -o tb_edge_top

status=0
./obj_dir/tb_edge_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Test passed" sim.log; then
  echo "simulation did not finish cleanly"
  exit 1
fi
echo "simulation finished without errors"
